// File: all.f
source/bridge_pkg.sv
source/settings_if.sv
source/settings_regs.sv
source/word_unpacker.sv
source/save_buffer.sv
source/bridge_read_mux.sv
source/snes_bridge_top.sv
dv/tb_top.sv

// File: dv/tb_top.sv
// Testbench for the host-bridge top level. Drives bridge reads and writes on
// clk_74a and checks the DUT with concurrent assertions against reference
// models of the settings bank, the reset hold, the rom port and read-back.

`timescale 1ns/10ps

module tb_top
  import bridge_pkg::*;
();

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;
  localparam int NUM_SETTINGS    = 9;

  logic       clk_74a;
  logic       pll_core_locked;
  addr_t      bridge_addr;
  logic       bridge_rd;
  logic       bridge_wr;
  data_t      bridge_wr_data;
  data_t      bridge_rd_data;
  logic       bridge_endian_little;
  logic       download;
  logic [3:0] rom_size;
  logic [7:0] rom_type;
  logic [3:0] ram_size;
  logic       pal;
  logic       multitap;
  logic       lightgun_enabled;
  logic       lightgun_type;
  logic [7:0] aim_speed;
  logic       video_4_3;
  logic       core_reset;
  logic       rom_wr;
  rom_addr_t  rom_addr;
  half_t      rom_data;

  // reference models
  data_t       exp_reg [NUM_SETTINGS];
  data_t       save_model [128];
  data_t       exp_rd_data;
  logic [31:0] exp_hold;
  logic        settings_ok;
  logic        rom_hit;

  int          error_count;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng;

  snes_bridge_top u_dut (.*);

  always #10 clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic addr_t setting_addr(input int idx);
    case (idx)
      0:       return ADDR_DOWNLOAD;
      1:       return ADDR_ROM_SIZE;
      2:       return ADDR_ROM_TYPE;
      3:       return ADDR_RAM_SIZE;
      4:       return ADDR_PAL;
      5:       return ADDR_MULTITAP;
      6:       return ADDR_LIGHTGUN;
      7:       return ADDR_AIM_SPEED;
      default: return ADDR_VIDEO_4_3;
    endcase
  endfunction

  // bits each register keeps
  function automatic data_t setting_mask(input int idx);
    case (idx)
      1, 3:    return 32'h0000_000F;
      2, 7:    return 32'h0000_00FF;
      6:       return 32'h0000_0003;
      default: return 32'h0000_0001;
    endcase
  endfunction

  function automatic int setting_index(input addr_t addr);
    for (int i = 0; i < NUM_SETTINGS; i++) begin
      if (setting_addr(i) == addr) return i;
    end
    return -1;
  endfunction

  function automatic data_t expected_read(input addr_t addr);
    int idx;
    idx = setting_index(addr);
    if (addr[31:28] == WINDOW_SAVE) return save_model[addr[8:2]];
    if (idx >= 0) return exp_reg[idx];
    return 32'd0;
  endfunction

  task automatic record_fail(input string msg);
    error_count++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_74a);
  endtask

  // one-cycle strobe, then one idle cycle
  task automatic bus_write(input addr_t addr, input data_t data);
    @(posedge clk_74a);
    #2;
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    if (addr[31:28] == WINDOW_SAVE) save_model[addr[8:2]] = data;
    @(posedge clk_74a);
    #2;
    bridge_wr = 1'b0;
  endtask

  task automatic bus_read(input addr_t addr);
    @(posedge clk_74a);
    #2;
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(posedge clk_74a);
    #2;
    bridge_rd = 1'b0;
  endtask

  task automatic end_test(input string name, input int errors_before);
    idle(4);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // models and checks
  ////////////////////////////////////////////////////////////////////////////

  assign rom_hit = bridge_wr && (bridge_addr[31:28] == WINDOW_ROM);

  assign settings_ok = (download == exp_reg[0][0]) && (rom_size == exp_reg[1][3:0]) &&
                       (rom_type == exp_reg[2][7:0]) && (ram_size == exp_reg[3][3:0]) &&
                       (pal == exp_reg[4][0]) && (multitap == exp_reg[5][0]) &&
                       (lightgun_enabled == exp_reg[6][0]) &&
                       (lightgun_type == exp_reg[6][1]) &&
                       (aim_speed == exp_reg[7][7:0]) && (video_4_3 == exp_reg[8][0]);

  always @(posedge clk_74a or negedge pll_core_locked) begin
    int idx;
    if (!pll_core_locked) begin
      for (int i = 0; i < NUM_SETTINGS; i++) begin
        exp_reg[i] <= 32'd0;
      end
      exp_rd_data <= 32'd0;
      exp_hold    <= 32'd0;
    end else begin
      idx = setting_index(bridge_addr);
      if (bridge_wr && idx >= 0) exp_reg[idx] <= bridge_wr_data & setting_mask(idx);
      if (bridge_wr && bridge_addr == ADDR_CORE_RESET) exp_hold <= RESET_HOLD_CYCLES;
      else if (exp_hold != 32'd0) exp_hold <= exp_hold - 32'd1;
      if (bridge_rd) exp_rd_data <= expected_read(bridge_addr);
    end
  end

  a_settings : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settings_ok) else record_fail("settings outputs differ from the register model");

  a_read_data : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_rd_data == exp_rd_data)
    else record_fail($sformatf("read data %h, expected %h",
                               $sampled(bridge_rd_data), $sampled(exp_rd_data)));

  a_hold : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    core_reset == (exp_hold != 32'd0)) else record_fail("core_reset differs from hold model");

  a_unlocked : assert property (@(posedge clk_74a) !pll_core_locked |-> core_reset)
    else record_fail("core_reset low while the pll is unlocked");

  a_endian : assert property (@(posedge clk_74a) !bridge_endian_little)
    else record_fail("bridge_endian_little is not 0");

  // upper halfword at N+1, lower one at N+2 and address + 2
  a_rom_first : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $past(rom_hit) |-> rom_wr && rom_addr == $past(bridge_addr[24:0]) &&
    rom_data == $past(bridge_wr_data[31:16])) else record_fail("rom first beat wrong");

  a_rom_second : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $past(rom_hit, 2) |-> rom_wr && rom_addr == $past(bridge_addr[24:0], 2) + 25'd2 &&
    rom_data == $past(bridge_wr_data[15:0], 2)) else record_fail("rom second beat wrong");

  a_rom_idle : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !$past(rom_hit) && !$past(rom_hit, 2) |-> !rom_wr)
    else record_fail("rom_wr high without a rom window write");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int    mark;
    addr_t addr;
    clk_74a         = 1'b0;
    pll_core_locked = 1'b0;
    bridge_addr     = 32'd0;
    bridge_rd       = 1'b0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = 32'd0;
    error_count     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    rng             = 32'h959f_38a4;
    repeat (8) @(posedge clk_74a);
    #2;
    pll_core_locked = 1'b1;

    mark = error_count;
    idle(4);
    end_test("reset values", mark);

    mark = error_count;
    for (int round = 0; round < 4; round++) begin
      for (int i = 0; i < NUM_SETTINGS; i++) begin
        rng = xorshift32(rng);
        bus_write(setting_addr(i), rng);
        bus_read(setting_addr(i));
      end
    end
    end_test("settings write and read-back", mark);

    mark = error_count;
    for (int i = 0; i < 16; i++) begin
      rng  = xorshift32(rng);
      addr = {WINDOW_ROM, rng[27:0]};
      rng  = xorshift32(rng);
      bus_write(addr, rng);
    end
    end_test("rom window unpacking", mark);

    mark = error_count;
    for (int i = 0; i < 32; i++) begin
      rng  = xorshift32(rng);
      addr = {WINDOW_SAVE, 19'd0, rng[8:2], 2'b00};
      rng  = xorshift32(rng);
      bus_write(addr, rng);
      idle(2);
      bus_read(addr);
    end
    // unmapped reads
    bus_read(32'h0000_0300);
    bus_read(32'h3000_0000);
    bus_read(ADDR_CORE_RESET);
    end_test("save buffer read-back", mark);

    mark = error_count;
    rng = xorshift32(rng);
    bus_write(ADDR_CORE_RESET, rng);
    idle(1000);
    end_test("core reset hold", mark);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_74a);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: source/bridge_pkg.sv
// Shared types and constants for the host-bridge side of the console core.
// Holds the bridge address map, the window selects and the reset hold length.
// Modules pull these in by a wildcard import in their header.

package bridge_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus and memory types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // one memory halfword
  typedef logic [15:0] half_t;

  // byte addresses into the rom and save spaces
  typedef logic [24:0] rom_addr_t;
  typedef logic [16:0] save_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  // top nibble of the bridge address
  localparam logic [3:0] WINDOW_ROM  = 4'h1;
  localparam logic [3:0] WINDOW_SAVE = 4'h2;

  // settings registers
  localparam addr_t ADDR_DOWNLOAD   = 32'h0000_0000;
  localparam addr_t ADDR_ROM_SIZE   = 32'h0000_0004;
  localparam addr_t ADDR_ROM_TYPE   = 32'h0000_0008;
  localparam addr_t ADDR_RAM_SIZE   = 32'h0000_000C;
  localparam addr_t ADDR_PAL        = 32'h0000_0010;
  localparam addr_t ADDR_CORE_RESET = 32'h0000_0050;
  localparam addr_t ADDR_MULTITAP   = 32'h0000_0100;
  localparam addr_t ADDR_LIGHTGUN   = 32'h0000_0104;
  localparam addr_t ADDR_AIM_SPEED  = 32'h0000_0108;
  localparam addr_t ADDR_VIDEO_4_3  = 32'h0000_0200;

  ////////////////////////////////////////////////////////////////////////////
  // sizes and counts
  ////////////////////////////////////////////////////////////////////////////

  // cycles the core is held in reset after a host request
  localparam logic [31:0] RESET_HOLD_CYCLES = 32'h0010_0000;

  // save buffer keeps 512 bytes
  localparam int SAVE_BUF_ADDR_BITS = 9;

endpackage

// File: source/bridge_read_mux.sv
// Host read-back path. Decodes the read address and returns a settings
// field or a save buffer word one cycle after the read strobe.
// Unmapped addresses read as 0.

`timescale 1ns/10ps

module bridge_read_mux
  import bridge_pkg::*;
(
  input  logic       clk_74a,
  input  logic       pll_core_locked,
  input  addr_t      bridge_addr,
  input  logic       bridge_rd,
  input  logic       bridge_wr,
  settings_if.sink   settings,
  input  data_t      save_data,
  output logic       save_rd,
  output save_addr_t save_rd_addr,
  output data_t      bridge_rd_data
);

  logic  save_hit;
  data_t settings_value;
  data_t settings_q;
  // last read went to the save window
  logic  sel_save;

  // save buffer registers its own word on the same edge
  assign save_hit     = bridge_rd && (bridge_addr[31:28] == WINDOW_SAVE);
  assign save_rd      = save_hit;
  assign save_rd_addr = bridge_addr[$bits(save_addr_t)-1:0];

  always_comb begin
    case (bridge_addr)
      ADDR_DOWNLOAD:  settings_value = {31'd0, settings.download};
      ADDR_ROM_SIZE:  settings_value = {28'd0, settings.rom_size};
      ADDR_ROM_TYPE:  settings_value = {24'd0, settings.rom_type};
      ADDR_RAM_SIZE:  settings_value = {28'd0, settings.ram_size};
      ADDR_PAL:       settings_value = {31'd0, settings.pal};
      ADDR_MULTITAP:  settings_value = {31'd0, settings.multitap};
      ADDR_LIGHTGUN:  settings_value = {30'd0, settings.lightgun_type, settings.lightgun_enabled};
      ADDR_AIM_SPEED: settings_value = {24'd0, settings.aim_speed};
      ADDR_VIDEO_4_3: settings_value = {31'd0, settings.video_4_3};
      default:        settings_value = 32'd0;
    endcase
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      sel_save   <= 1'b0;
      settings_q <= 32'd0;
    end else if (bridge_rd) begin
      sel_save   <= save_hit;
      settings_q <= settings_value;
    end
  end

  assign bridge_rd_data = sel_save ? save_data : settings_q;

  a_rd_wr_exclusive : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !(bridge_rd && bridge_wr)
  ) else $error("bridge read and write strobes high together");

endmodule

// File: source/save_buffer.sv
// On-chip save memory. Written one halfword at a time from the save window
// unpacker and read back one 32-bit word at a time for the host.
// Only the low SAVE_BUF_ADDR_BITS of the byte address are kept.

`timescale 1ns/10ps

module save_buffer
  import bridge_pkg::*;
(
  input  logic       clk_74a,
  input  logic       wr_en,
  input  save_addr_t wr_addr,
  input  half_t      wr_data,
  input  logic       rd_en,
  input  save_addr_t rd_addr,
  output data_t      rd_data
);

  // word index within the buffer
  logic [SAVE_BUF_ADDR_BITS-3:0] wr_index;
  logic [SAVE_BUF_ADDR_BITS-3:0] rd_index;

  // even bank holds bits 31:16 of each word, odd bank bits 15:0
  half_t even_bank [2**(SAVE_BUF_ADDR_BITS-2)];
  half_t odd_bank  [2**(SAVE_BUF_ADDR_BITS-2)];

  assign wr_index = wr_addr[SAVE_BUF_ADDR_BITS-1:2];
  assign rd_index = rd_addr[SAVE_BUF_ADDR_BITS-1:2];

  ////////////////////////////////////////////////////////////////////////////
  // halfword write, byte address bit 1 picks the bank
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (wr_en && !wr_addr[1]) begin
      even_bank[wr_index] <= wr_data;
    end
    if (wr_en && wr_addr[1]) begin
      odd_bank[wr_index] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word read
  ////////////////////////////////////////////////////////////////////////////

  // holds the last word until the next read
  always_ff @(posedge clk_74a) begin
    if (rd_en) begin
      rd_data <= {even_bank[rd_index], odd_bank[rd_index]};
    end
  end

endmodule

// File: source/settings_if.sv
// Decoded core settings, driven by the register bank and read by the
// bridge read-back path.

`timescale 1ns/10ps

interface settings_if;

  logic       download;
  logic [3:0] rom_size;
  logic [7:0] rom_type;
  logic [3:0] ram_size;
  logic       pal;
  logic       multitap;
  logic       lightgun_enabled;
  logic       lightgun_type;
  logic [7:0] aim_speed;
  logic       video_4_3;

  // register bank side
  modport source (
    output download, rom_size, rom_type, ram_size, pal,
    output multitap, lightgun_enabled, lightgun_type, aim_speed, video_4_3
  );

  // read-back side
  modport sink (
    input download, rom_size, rom_type, ram_size, pal,
    input multitap, lightgun_enabled, lightgun_type, aim_speed, video_4_3
  );

endinterface

// File: source/settings_regs.sv
// Settings register bank on the host bridge.
// Host writes to the settings map load the fields one cycle later. A write
// to the core reset register starts a timed hold of the core reset.

`timescale 1ns/10ps

module settings_regs
  import bridge_pkg::*;
(
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  addr_t          bridge_addr,
  input  logic           bridge_wr,
  input  data_t          bridge_wr_data,
  settings_if.source     settings,
  output logic           core_reset
);

  // remaining cycles of the core reset hold
  logic [31:0] hold_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // settings decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings.download         <= 1'b0;
      settings.rom_size         <= 4'd0;
      settings.rom_type         <= 8'd0;
      settings.ram_size         <= 4'd0;
      settings.pal              <= 1'b0;
      settings.multitap         <= 1'b0;
      settings.lightgun_enabled <= 1'b0;
      settings.lightgun_type    <= 1'b0;
      settings.aim_speed        <= 8'd0;
      settings.video_4_3        <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        ADDR_DOWNLOAD: begin
          settings.download <= bridge_wr_data[0];
        end
        ADDR_ROM_SIZE: begin
          settings.rom_size <= bridge_wr_data[3:0];
        end
        ADDR_ROM_TYPE: begin
          settings.rom_type <= bridge_wr_data[7:0];
        end
        ADDR_RAM_SIZE: begin
          settings.ram_size <= bridge_wr_data[3:0];
        end
        ADDR_PAL: begin
          settings.pal <= bridge_wr_data[0];
        end
        ADDR_MULTITAP: begin
          settings.multitap <= bridge_wr_data[0];
        end
        // enable in bit 0, gun type in bit 1
        ADDR_LIGHTGUN: begin
          settings.lightgun_enabled <= bridge_wr_data[0];
          settings.lightgun_type    <= bridge_wr_data[1];
        end
        ADDR_AIM_SPEED: begin
          settings.aim_speed <= bridge_wr_data[7:0];
        end
        ADDR_VIDEO_4_3: begin
          settings.video_4_3 <= bridge_wr_data[0];
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // core reset hold
  ////////////////////////////////////////////////////////////////////////////

  // any write restarts the hold whatever the data
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= 32'd0;
    end else if (bridge_wr && (bridge_addr == ADDR_CORE_RESET)) begin
      hold_cnt <= RESET_HOLD_CYCLES;
    end else if (hold_cnt != 32'd0) begin
      hold_cnt <= hold_cnt - 32'd1;
    end
  end

  // also held while the pll is not locked
  assign core_reset = (hold_cnt != 32'd0) || !pll_core_locked;

  // core stays in reset for the whole hold
  a_reset_during_hold : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    (hold_cnt > 32'd1) |=> core_reset
  ) else $error("core_reset dropped before the hold counter ran out");

endmodule

// File: source/snes_bridge_top.sv
// Top level of the host-bridge side. Joins the bridge bus to the settings
// bank, the rom and save unpackers, the save buffer and the read-back mux.
// Everything runs on clk_74a; pll_core_locked low resets the control state.

`timescale 1ns/10ps

module snes_bridge_top
  import bridge_pkg::*;
(
  input  logic       clk_74a,
  input  logic       pll_core_locked,

  // bridge bus
  input  addr_t      bridge_addr,
  input  logic       bridge_rd,
  input  logic       bridge_wr,
  input  data_t      bridge_wr_data,
  output data_t      bridge_rd_data,
  output logic       bridge_endian_little,

  // core settings
  output logic       download,
  output logic [3:0] rom_size,
  output logic [7:0] rom_type,
  output logic [3:0] ram_size,
  output logic       pal,
  output logic       multitap,
  output logic       lightgun_enabled,
  output logic       lightgun_type,
  output logic [7:0] aim_speed,
  output logic       video_4_3,

  output logic       core_reset,

  // rom write port
  output logic       rom_wr,
  output rom_addr_t  rom_addr,
  output half_t      rom_data
);

  settings_if u_settings_if ();

  logic       save_wr;
  save_addr_t save_wr_addr;
  half_t      save_wr_data;
  logic       save_rd;
  save_addr_t save_rd_addr;
  data_t      save_rd_data;

  // big-endian bridge
  assign bridge_endian_little = 1'b0;

  assign download         = u_settings_if.download;
  assign rom_size         = u_settings_if.rom_size;
  assign rom_type         = u_settings_if.rom_type;
  assign ram_size         = u_settings_if.ram_size;
  assign pal              = u_settings_if.pal;
  assign multitap         = u_settings_if.multitap;
  assign lightgun_enabled = u_settings_if.lightgun_enabled;
  assign lightgun_type    = u_settings_if.lightgun_type;
  assign aim_speed        = u_settings_if.aim_speed;
  assign video_4_3        = u_settings_if.video_4_3;

  ////////////////////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////////////////////

  settings_regs u_settings_regs (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .settings        (u_settings_if.source),
    .core_reset      (core_reset)
  );

  word_unpacker #(
    .payload_addr_t (rom_addr_t),
    .WINDOW         (WINDOW_ROM)
  ) u_rom_unpacker (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .mem_wr          (rom_wr),
    .mem_addr        (rom_addr),
    .mem_data        (rom_data)
  );

  word_unpacker #(
    .payload_addr_t (save_addr_t),
    .WINDOW         (WINDOW_SAVE)
  ) u_save_unpacker (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .mem_wr          (save_wr),
    .mem_addr        (save_wr_addr),
    .mem_data        (save_wr_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // save memory and read-back
  ////////////////////////////////////////////////////////////////////////////

  save_buffer u_save_buffer (
    .clk_74a (clk_74a),
    .wr_en   (save_wr),
    .wr_addr (save_wr_addr),
    .wr_data (save_wr_data),
    .rd_en   (save_rd),
    .rd_addr (save_rd_addr),
    .rd_data (save_rd_data)
  );

  bridge_read_mux u_bridge_read_mux (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .bridge_wr       (bridge_wr),
    .settings        (u_settings_if.sink),
    .save_data       (save_rd_data),
    .save_rd         (save_rd),
    .save_rd_addr    (save_rd_addr),
    .bridge_rd_data  (bridge_rd_data)
  );

endmodule

// File: source/word_unpacker.sv
// Splits a 32-bit host write inside one address window into two 16-bit
// memory writes: upper halfword first, then the lower one at address + 2.
// The address type sets how many byte-address bits the memory keeps.

`timescale 1ns/10ps

module word_unpacker
  import bridge_pkg::*;
#(
  parameter type        payload_addr_t = rom_addr_t,
  parameter logic [3:0] WINDOW         = WINDOW_ROM
) (
  input  logic          clk_74a,
  input  logic          pll_core_locked,
  input  addr_t         bridge_addr,
  input  logic          bridge_wr,
  input  data_t         bridge_wr_data,
  output logic          mem_wr,
  output payload_addr_t mem_addr,
  output half_t         mem_data
);

  logic  window_hit;
  // second beat still to go
  logic  pending;
  half_t low_half;

  assign window_hit = bridge_wr && (bridge_addr[31:28] == WINDOW);

  ////////////////////////////////////////////////////////////////////////////
  // beat control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      mem_wr  <= 1'b0;
      pending <= 1'b0;
    end else if (window_hit) begin
      mem_wr  <= 1'b1;
      pending <= 1'b1;
    end else if (pending) begin
      mem_wr  <= 1'b1;
      pending <= 1'b0;
    end else begin
      mem_wr  <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // address and data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (window_hit) begin
      // big-endian bridge, bits 31:16 go out first
      mem_addr <= bridge_addr[$bits(payload_addr_t)-1:0];
      mem_data <= bridge_wr_data[31:16];
      low_half <= bridge_wr_data[15:0];
    end else if (pending) begin
      mem_addr <= mem_addr + payload_addr_t'(2);
      mem_data <= low_half;
    end
  end

  // host must leave a gap after each window write
  a_no_overlap : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    window_hit |-> !pending
  ) else $error("window write arrived during the second beat");

endmodule
